/* all.f */
source/kv_pkg.sv
source/sync_fifo.sv
source/request_splitter.sv
source/key_assembler.sv
source/key_hasher.sv
source/lookup_issue.sv
source/kv_lookup_front.sv
sim/kv_front_properties.sv
sim/tb_kv_lookup_front.sv

/* run_sim.sh */
#!/bin/sh
# build the lookup front end testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_kv_lookup_front -f all.f > build.log 2>&1
if [ $? -ne 0 ]; then
    cat build.log
    echo "build failed, see build.log"
    exit 1
fi

./obj_dir/Vtb_kv_lookup_front > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "TESTBENCH FAILED" sim.log; then
    exit 1
fi
exit 0

/* sim/kv_front_properties.sv */
/*
 * kv_front_properties
 * output protocol checks for the lookup front end, bound to the top level
 */
`default_nettype none

module kv_front_properties
    import kv_pkg::*;
(
    input wire logic        clk,
    input wire logic        rst,
    input wire ht_cmd_t     ht_rd_cmd,
    input wire logic        ht_rd_cmd_valid,
    input wire logic        ht_rd_cmd_stall,
    input wire lookup_rec_t lookup,
    input wire logic        lookup_valid,
    input wire logic        lookup_ready
);
    timeunit 1ns;
    timeprecision 1ps;

    // a stalled command stays put
    property cmd_held_while_stalled;
        @(posedge clk) disable iff (rst)
        ht_rd_cmd_valid && ht_rd_cmd_stall |=> ht_rd_cmd_valid && $stable(ht_rd_cmd);
    endproperty

    property lookup_held_while_blocked;
        @(posedge clk) disable iff (rst)
        lookup_valid && !lookup_ready |=> lookup_valid && $stable(lookup);
    endproperty

    // ------------------------------
    // reset behavior
    // ------------------------------
    property quiet_in_reset;
        @(posedge clk) rst |=> !ht_rd_cmd_valid && !lookup_valid;
    endproperty

    a_cmd_held: assert property (cmd_held_while_stalled)
        else $error("read command changed while stalled");
    a_lookup_held: assert property (lookup_held_while_blocked)
        else $error("lookup record changed while not accepted");
    a_quiet_reset: assert property (quiet_in_reset)
        else $error("output valid raised during reset");

endmodule

bind kv_lookup_front kv_front_properties u_properties (
    .clk            (clk),
    .rst            (rst),
    .ht_rd_cmd      (ht_rd_cmd),
    .ht_rd_cmd_valid(ht_rd_cmd_valid),
    .ht_rd_cmd_stall(ht_rd_cmd_stall),
    .lookup         (lookup),
    .lookup_valid   (lookup_valid),
    .lookup_ready   (lookup_ready)
);

`default_nettype wire

/* sim/tb_kv_lookup_front.sv */
/*
 * tb_kv_lookup_front
 * random requests into the lookup front end, checked against a queue model
 */
`default_nettype none

module tb_kv_lookup_front
    import kv_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    typedef logic [MAX_KEY_WORDS-1:0][KEY_WORD_WIDTH-1:0] key_words_t;

    localparam int WAIT_LIMIT = 5000;
    localparam int SEED       = 32'hfa32_7a33;

    logic        clk             = 1'b0;
    logic        rst             = 1'b1;
    req_beat_u   in_beat         = '0;
    logic        in_valid        = 1'b0;
    logic        in_last         = 1'b0;
    logic        in_ready;
    ht_cmd_t     ht_rd_cmd;
    logic        ht_rd_cmd_valid;
    logic        ht_rd_cmd_stall = 1'b0;
    lookup_rec_t lookup;
    logic        lookup_valid;
    logic        lookup_ready    = 1'b1;

    integer      seed            = SEED;
    integer      bp_seed         = SEED + 1;
    logic        bp_on           = 1'b0;
    logic        timed_out       = 1'b0;
    int          errors          = 0;
    int          checks          = 0;
    int          sent_count      = 0;
    int          cmd_seen        = 0;
    int          rec_seen        = 0;
    ht_cmd_t     exp_cmd_q[$];
    lookup_rec_t exp_rec_q[$];

    kv_lookup_front u_dut (
        .clk            (clk),
        .rst            (rst),
        .in_beat        (in_beat),
        .in_valid       (in_valid),
        .in_last        (in_last),
        .in_ready       (in_ready),
        .ht_rd_cmd      (ht_rd_cmd),
        .ht_rd_cmd_valid(ht_rd_cmd_valid),
        .ht_rd_cmd_stall(ht_rd_cmd_stall),
        .lookup         (lookup),
        .lookup_valid   (lookup_valid),
        .lookup_ready   (lookup_ready)
    );

    always #4 clk = ~clk;

    // ------------------------------
    // reference model
    // ------------------------------
    function automatic logic [31:0] rotate_left(input logic [31:0] value, input int amount);
        logic [63:0] doubled;
        doubled = {value, value};
        return doubled[63-amount -: 32];
    endfunction

    function automatic hash_pair_t expected_hash(input key_words_t words, input int count);
        logic [31:0] h1;
        logic [31:0] h2;
        logic [31:0] lo;
        logic [31:0] hi;
        hash_pair_t  result;
        h1 = HASH_SEED_A;
        h2 = HASH_SEED_B;
        for (int i = 0; i < count; i++) begin
            lo = words[i][31:0];
            hi = words[i][63:32];
            h1 = rotate_left(h1, HASH_ROT_A) ^ lo ^ hi;
            h2 = (rotate_left(h2, HASH_ROT_B) + lo) ^ hi;
        end
        result.hash_one = h1;
        result.hash_two = h2;
        return result;
    endfunction

    // last two words, earlier one high; a lone word gets a zero high half
    function automatic logic [KEY_WIDTH-1:0] expected_key(input key_words_t words,
                                                          input int count);
        if (count == 1) begin
            return {{KEY_WORD_WIDTH{1'b0}}, words[0]};
        end
        return {words[count-2], words[count-1]};
    endfunction

    // ------------------------------
    // compare tasks
    // ------------------------------
    task automatic check_cmd(input ht_cmd_t expected, input ht_cmd_t actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("[FAIL] %0d ns: read command %h, expected %h", $time, actual, expected);
        end
    endtask

    task automatic check_lookup(input lookup_rec_t expected, input lookup_rec_t actual);
        checks++;
        if (actual.hash !== expected.hash) begin
            errors++;
            $display("[FAIL] %0d ns: lookup hash %h, expected %h",
                     $time, actual.hash, expected.hash);
        end
        if (actual.meta !== expected.meta) begin
            errors++;
            $display("[FAIL] %0d ns: lookup metadata %h, expected %h",
                     $time, actual.meta, expected.meta);
        end
        if (actual.key !== expected.key) begin
            errors++;
            $display("[FAIL] %0d ns: lookup key %h, expected %h",
                     $time, actual.key, expected.key);
        end
    endtask

    task automatic check_count(input string what, input int actual, input int expected);
        checks++;
        if (actual != expected) begin
            errors++;
            $display("[FAIL] %0d ns: %s count %0d, expected %0d", $time, what, actual, expected);
        end
    endtask

    task automatic check_level(input string what, input logic actual, input logic expected);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("[FAIL] %0d ns: %s is %b, expected %b", $time, what, actual, expected);
        end
    endtask

    task automatic report_timeout(input string what);
        $display("timeout: %s did not happen within %0d cycles", what, WAIT_LIMIT);
        timed_out = 1'b1;
    endtask

    // ------------------------------
    // output side, back-pressure and capture
    // ------------------------------
    always @(negedge clk) begin
        if (bp_on) begin
            ht_rd_cmd_stall = (($random(bp_seed) & 7) < 3);
            lookup_ready    = (($random(bp_seed) & 7) >= 3);
        end else begin
            ht_rd_cmd_stall = 1'b0;
            lookup_ready    = 1'b1;
        end
        // handshakes below complete on the coming rising edge
        if (!rst && ht_rd_cmd_valid && !ht_rd_cmd_stall) begin
            cmd_seen++;
            if (exp_cmd_q.size() == 0) begin
                errors++;
                $display("[FAIL] %0d ns: read command with no request outstanding", $time);
            end else begin
                check_cmd(exp_cmd_q.pop_front(), ht_rd_cmd);
            end
        end
        if (!rst && lookup_valid && lookup_ready) begin
            rec_seen++;
            if (exp_rec_q.size() == 0) begin
                errors++;
                $display("[FAIL] %0d ns: lookup record with no request outstanding", $time);
            end else begin
                check_lookup(exp_rec_q.pop_front(), lookup);
            end
        end
    end

    // ------------------------------
    // input side
    // ------------------------------
    task automatic send_beat(input req_beat_u beat, input logic last);
        int waited;
        waited = 0;
        @(negedge clk);
        in_beat  = beat;
        in_last  = last;
        in_valid = 1'b1;
        while (!in_ready && waited < WAIT_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (!in_ready) begin
            report_timeout("in_ready");
        end
    endtask

    task automatic release_input();
        @(negedge clk);
        in_valid = 1'b0;
        in_last  = 1'b0;
    endtask

    task automatic send_request(input int lo, input int hi);
        req_beat_u             beat;
        key_words_t            words;
        logic [META_WIDTH-1:0] meta;
        hash_pair_t            hash;
        ht_cmd_t               cmd;
        lookup_rec_t           rec;
        int                    count;
        int                    n_beats;
        meta  = {$random(seed), $random(seed), $random(seed)};
        count = lo + int'($unsigned($random(seed)) % (hi - lo + 1));
        for (int i = 0; i < MAX_KEY_WORDS; i++) begin
            words[i] = {$random(seed), $random(seed)};
        end
        hash       = expected_hash(words, count);
        cmd        = '0;
        cmd.prefix = CMD_PREFIX;
        cmd.burst  = CMD_BURST_ONE;
        cmd.bucket = 24'(hash.hash_one[HT_ADDR_BITS-1:0]);
        rec.hash   = hash;
        rec.meta   = meta;
        rec.key    = expected_key(words, count);
        exp_cmd_q.push_back(cmd);
        exp_rec_q.push_back(rec);
        sent_count++;

        beat              = '0;
        beat.hdr.meta     = meta;
        beat.hdr.key_count = 8'(count);
        beat.hdr.reserved = 24'($random(seed));
        send_beat(beat, 1'b0);
        // unused upper word of an odd count stays random filler
        n_beats = (count + 1) / 2;
        for (int b = 0; b < n_beats; b++) begin
            if (!timed_out) begin
                beat.keys.word_zero = words[2*b];
                beat.keys.word_one  = words[2*b+1];
                send_beat(beat, b == n_beats - 1);
            end
        end
        // occasional idle gap between requests
        if (($random(seed) & 3) == 0) begin
            release_input();
        end
    endtask

    task automatic wait_for_drain();
        int waited;
        waited = 0;
        while ((exp_cmd_q.size() != 0 || exp_rec_q.size() != 0) && waited < WAIT_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (exp_cmd_q.size() != 0 || exp_rec_q.size() != 0) begin
            report_timeout("output drain");
        end
        // room for any duplicate to show up
        repeat (20) @(negedge clk);
    endtask

    task automatic run_batch(input string name, input int n, input int lo, input int hi,
                             input logic bp);
        int err0;
        int cmd0;
        int rec0;
        err0 = errors;
        cmd0 = cmd_seen;
        rec0 = rec_seen;
        @(posedge clk);
        bp_on = bp;
        for (int i = 0; i < n; i++) begin
            if (!timed_out) begin
                send_request(lo, hi);
            end
        end
        release_input();
        if (!timed_out) begin
            wait_for_drain();
        end
        @(posedge clk);
        bp_on = 1'b0;
        check_count("read command", cmd_seen - cmd0, n);
        check_count("lookup record", rec_seen - rec0, n);
        $display("test %-14s %0d requests, %0d errors", name, n, errors - err0);
    endtask

    task automatic test_reset();
        int err0;
        int waited;
        err0   = errors;
        waited = 0;
        repeat (8) begin
            @(negedge clk);
            check_level("ht_rd_cmd_valid in reset", ht_rd_cmd_valid, 1'b0);
            check_level("lookup_valid in reset", lookup_valid, 1'b0);
        end
        rst = 1'b0;
        while (!in_ready && waited < WAIT_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (!in_ready) begin
            report_timeout("in_ready after reset");
        end
        repeat (6) begin
            @(negedge clk);
            check_level("ht_rd_cmd_valid before requests", ht_rd_cmd_valid, 1'b0);
            check_level("lookup_valid before requests", lookup_valid, 1'b0);
        end
        $display("test %-14s %0d errors", "reset", errors - err0);
    endtask

    initial begin
        test_reset();
        if (!timed_out) begin
            run_batch("single_word", 24, 1, 1, 1'b0);
        end
        if (!timed_out) begin
            run_batch("multi_word", 40, 2, MAX_KEY_WORDS, 1'b0);
        end
        if (!timed_out) begin
            run_batch("request_order", 200, 1, MAX_KEY_WORDS, 1'b0);
        end
        if (!timed_out) begin
            run_batch("backpressure", 200, 1, MAX_KEY_WORDS, 1'b1);
        end
        $display("requests %0d, checks %0d, errors %0d", sent_count, checks, errors);
        if (errors == 0 && !timed_out) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* source/key_assembler.sv */
/*
 * key_assembler
 * shifts key words into a 128-bit register and presents the last two
 * words of a request as the wide key
 */
`default_nettype none

module key_assembler
    import kv_pkg::*;
(
    input  wire logic                      clk,
    input  wire logic                      rst,
    input  wire logic [KEY_WORD_WIDTH-1:0] key_word,
    input  wire logic                      key_valid,
    input  wire logic                      key_last,
    output logic                           key_ready,
    output logic      [KEY_WIDTH-1:0]      wide_key,
    output logic                           wide_valid,
    input  wire logic                      wide_ready
);

    logic [KEY_WIDTH-1:0] assembly;
    logic                 take;

    // blocked while a finished key waits for the buffer
    assign key_ready = !wide_valid || wide_ready;
    assign take      = key_valid && key_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            assembly   <= '0;
            wide_valid <= 1'b0;
        end else begin
            if (wide_valid && wide_ready) begin
                wide_valid <= 1'b0;
            end
            if (take) begin
                if (key_last) begin
                    // start clean, so a one-word key gets a zero high half
                    assembly   <= '0;
                    wide_valid <= 1'b1;
                end else begin
                    assembly <= {assembly[KEY_WIDTH-KEY_WORD_WIDTH-1:0], key_word};
                end
            end
        end
    end

    // earlier word lands in the high half
    always_ff @(posedge clk) begin
        if (take && key_last) begin
            wide_key <= {assembly[KEY_WIDTH-KEY_WORD_WIDTH-1:0], key_word};
        end
    end

endmodule

`default_nettype wire

/* source/key_hasher.sv */
/*
 * key_hasher
 * folds every key word of a request into two 32-bit hashes,
 * held at the output until taken
 */
`default_nettype none

module key_hasher
    import kv_pkg::*;
(
    input  wire logic                      clk,
    input  wire logic                      rst,
    input  wire logic [KEY_WORD_WIDTH-1:0] key_word,
    input  wire logic                      key_valid,
    input  wire logic                      key_last,
    output logic                           key_ready,
    output hash_pair_t                     hash,
    output logic                           hash_valid,
    input  wire logic                      hash_ready
);

    logic [31:0] run_one;
    logic [31:0] run_two;
    logic [31:0] next_one;
    logic [31:0] next_two;
    logic [31:0] word_lo;
    logic [31:0] word_hi;
    logic        take;

    function automatic logic [31:0] rotl(input logic [31:0] value, input int amount);
        return (value << amount) | (value >> (32 - amount));
    endfunction

    assign key_ready = !hash_valid;
    assign take      = key_valid && key_ready;

    assign word_lo = key_word[KEY_WORD_WIDTH/2-1:0];
    assign word_hi = key_word[KEY_WORD_WIDTH-1:KEY_WORD_WIDTH/2];

    // ------------------------------
    // per-word mixing
    // ------------------------------
    assign next_one = rotl(run_one, HASH_ROT_A) ^ word_lo ^ word_hi;
    // add wraps at 32 bits
    assign next_two = (rotl(run_two, HASH_ROT_B) + word_lo) ^ word_hi;

    always_ff @(posedge clk) begin
        if (rst) begin
            run_one    <= HASH_SEED_A;
            run_two    <= HASH_SEED_B;
            hash_valid <= 1'b0;
        end else begin
            if (hash_valid && hash_ready) begin
                hash_valid <= 1'b0;
            end
            if (take) begin
                if (key_last) begin
                    // reseed for the next request
                    run_one    <= HASH_SEED_A;
                    run_two    <= HASH_SEED_B;
                    hash_valid <= 1'b1;
                end else begin
                    run_one <= next_one;
                    run_two <= next_two;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (take && key_last) begin
            hash.hash_one <= next_one;
            hash.hash_two <= next_two;
        end
    end

endmodule

`default_nettype wire

/* source/kv_lookup_front.sv */
/*
 * kv_lookup_front
 * request front end of the key-value store, from request beats to
 * hash table read commands and lookup records
 */
`default_nettype none

module kv_lookup_front
    import kv_pkg::*;
(
    input  wire logic        clk,
    input  wire logic        rst,
    input  wire req_beat_u   in_beat,
    input  wire logic        in_valid,
    input  wire logic        in_last,
    output logic             in_ready,
    output ht_cmd_t          ht_rd_cmd,
    output logic             ht_rd_cmd_valid,
    input  wire logic        ht_rd_cmd_stall,
    output lookup_rec_t      lookup,
    output logic             lookup_valid,
    input  wire logic        lookup_ready
);

    // buffered beats, last flag on top
    logic [BEAT_WIDTH:0]     buf_data;
    logic                    buf_valid;
    logic                    buf_ready;

    logic [META_WIDTH-1:0]   meta;
    logic                    meta_valid;
    logic                    meta_ready;
    logic [META_WIDTH-1:0]   meta_b;
    logic                    meta_b_valid;
    logic                    meta_b_ready;

    logic [KEY_WORD_WIDTH-1:0] key_word;
    logic                    key_valid;
    logic                    key_last;
    logic                    key_accept;
    logic                    asm_ready;
    logic                    hash_in_ready;

    logic [KEY_WIDTH-1:0]    wide_key;
    logic                    wide_valid;
    logic                    wide_ready;
    logic [KEY_WIDTH-1:0]    wide_key_b;
    logic                    wide_b_valid;
    logic                    wide_b_ready;

    hash_pair_t              hash;
    logic                    hash_valid;
    logic                    hash_ready;

    // a key word moves only when assembler and hasher both take it
    assign key_accept = key_valid && asm_ready && hash_in_ready;

    // ------------------------------
    // input side
    // ------------------------------
    sync_fifo #(
        .DATA_WIDTH(BEAT_WIDTH + 1),
        .ADDR_BITS (IN_FIFO_BITS)
    ) u_in_fifo (
        .clk      (clk),
        .rst      (rst),
        .in_data  ({in_last, in_beat}),
        .in_valid (in_valid),
        .in_ready (in_ready),
        .out_data (buf_data),
        .out_valid(buf_valid),
        .out_ready(buf_ready)
    );

    request_splitter u_splitter (
        .clk       (clk),
        .rst       (rst),
        .beat      (buf_data[BEAT_WIDTH-1:0]),
        .beat_valid(buf_valid),
        .beat_last (buf_data[BEAT_WIDTH]),
        .beat_ready(buf_ready),
        .meta      (meta),
        .meta_valid(meta_valid),
        .key_word  (key_word),
        .key_valid (key_valid),
        .key_last  (key_last),
        .meta_ready(meta_ready),
        .key_ready (key_accept)
    );

    sync_fifo #(
        .DATA_WIDTH(META_WIDTH),
        .ADDR_BITS (META_FIFO_BITS)
    ) u_meta_fifo (
        .clk      (clk),
        .rst      (rst),
        .in_data  (meta),
        .in_valid (meta_valid),
        .in_ready (meta_ready),
        .out_data (meta_b),
        .out_valid(meta_b_valid),
        .out_ready(meta_b_ready)
    );

    // ------------------------------
    // key and hash paths
    // ------------------------------
    key_assembler u_key_assembler (
        .clk       (clk),
        .rst       (rst),
        .key_word  (key_word),
        .key_valid (key_accept),
        .key_last  (key_last),
        .key_ready (asm_ready),
        .wide_key  (wide_key),
        .wide_valid(wide_valid),
        .wide_ready(wide_ready)
    );

    sync_fifo #(
        .DATA_WIDTH(KEY_WIDTH),
        .ADDR_BITS (KEY_FIFO_BITS)
    ) u_key_fifo (
        .clk      (clk),
        .rst      (rst),
        .in_data  (wide_key),
        .in_valid (wide_valid),
        .in_ready (wide_ready),
        .out_data (wide_key_b),
        .out_valid(wide_b_valid),
        .out_ready(wide_b_ready)
    );

    key_hasher u_key_hasher (
        .clk       (clk),
        .rst       (rst),
        .key_word  (key_word),
        .key_valid (key_accept),
        .key_last  (key_last),
        .key_ready (hash_in_ready),
        .hash      (hash),
        .hash_valid(hash_valid),
        .hash_ready(hash_ready)
    );

    lookup_issue u_lookup_issue (
        .clk            (clk),
        .rst            (rst),
        .wide_key       (wide_key_b),
        .wide_valid     (wide_b_valid),
        .hash           (hash),
        .hash_valid     (hash_valid),
        .meta           (meta_b),
        .meta_valid     (meta_b_valid),
        .wide_ready     (wide_b_ready),
        .hash_ready     (hash_ready),
        .meta_ready     (meta_b_ready),
        .ht_rd_cmd      (ht_rd_cmd),
        .ht_rd_cmd_valid(ht_rd_cmd_valid),
        .ht_rd_cmd_stall(ht_rd_cmd_stall),
        .lookup         (lookup),
        .lookup_valid   (lookup_valid),
        .lookup_ready   (lookup_ready)
    );

endmodule

`default_nettype wire

/* source/kv_pkg.sv */
/*
 * kv_pkg
 * widths, hash seeds and command constants shared by the lookup front end,
 * plus the request beat, hash, lookup and read command types
 */
`default_nettype none

package kv_pkg;

    // ------------------------------
    // widths and sizes
    // ------------------------------
    localparam int KEY_WORD_WIDTH = 64;
    localparam int KEY_WIDTH      = 128;
    localparam int META_WIDTH     = 96;
    localparam int BEAT_WIDTH     = 128;
    localparam int MAX_KEY_WORDS  = 4;
    localparam int HT_ADDR_BITS   = 23;

    // hash seeds and rotate amounts
    localparam logic [31:0] HASH_SEED_A = 32'h9e37_79b9;
    localparam logic [31:0] HASH_SEED_B = 32'h85eb_ca6b;
    localparam int          HASH_ROT_A  = 5;
    localparam int          HASH_ROT_B  = 11;

    // read command fields
    localparam logic [23:0] CMD_PREFIX    = 24'h000101;
    localparam logic [7:0]  CMD_BURST_ONE = 8'h01;

    // buffer depths, in address bits
    localparam int IN_FIFO_BITS   = 6;
    localparam int META_FIFO_BITS = 5;
    localparam int KEY_FIFO_BITS  = 5;

    // ------------------------------
    // request beat
    // ------------------------------
    typedef struct packed {
        logic [META_WIDTH-1:0] meta;
        logic [7:0]            key_count;
        logic [23:0]           reserved;
    } req_header_t;

    // word zero in the low half, consumed first
    typedef struct packed {
        logic [KEY_WORD_WIDTH-1:0] word_one;
        logic [KEY_WORD_WIDTH-1:0] word_zero;
    } key_beat_t;

    // first beat of a request is a header, the rest carry key words
    typedef union packed {
        req_header_t hdr;
        key_beat_t   keys;
    } req_beat_u;

    typedef struct packed {
        logic [31:0] hash_one;
        logic [31:0] hash_two;
    } hash_pair_t;

    typedef struct packed {
        hash_pair_t            hash;
        logic [META_WIDTH-1:0] meta;
        logic [KEY_WIDTH-1:0]  key;
    } lookup_rec_t;

    typedef struct packed {
        logic [23:0] prefix;
        logic [7:0]  burst;
        logic [7:0]  zero;
        logic [23:0] bucket;
    } ht_cmd_t;

endpackage

`default_nettype wire

/* source/lookup_issue.sv */
/*
 * lookup_issue
 * joins wide key, hash pair and metadata, then registers the hash table
 * read command and the lookup record, each draining on its own
 */
`default_nettype none

module lookup_issue
    import kv_pkg::*;
(
    input  wire logic                  clk,
    input  wire logic                  rst,
    input  wire logic [KEY_WIDTH-1:0]  wide_key,
    input  wire logic                  wide_valid,
    input  wire hash_pair_t            hash,
    input  wire logic                  hash_valid,
    input  wire logic [META_WIDTH-1:0] meta,
    input  wire logic                  meta_valid,
    output logic                       wide_ready,
    output logic                       hash_ready,
    output logic                       meta_ready,
    output ht_cmd_t                    ht_rd_cmd,
    output logic                       ht_rd_cmd_valid,
    input  wire logic                  ht_rd_cmd_stall,
    output lookup_rec_t                lookup,
    output logic                       lookup_valid,
    input  wire logic                  lookup_ready
);

    ht_cmd_t     cmd_next;
    lookup_rec_t rec_next;
    logic        cmd_free;
    logic        rec_free;
    logic        fire;

    // each output register empty or leaving this cycle
    assign cmd_free = !ht_rd_cmd_valid || !ht_rd_cmd_stall;
    assign rec_free = !lookup_valid || lookup_ready;

    assign fire       = wide_valid && hash_valid && meta_valid && cmd_free && rec_free;
    assign wide_ready = fire;
    assign hash_ready = fire;
    assign meta_ready = fire;

    // ------------------------------
    // output formatting
    // ------------------------------
    always_comb begin
        cmd_next        = '0;
        cmd_next.prefix = CMD_PREFIX;
        cmd_next.burst  = CMD_BURST_ONE;
        // bucket from hash one, upper bits stay zero
        cmd_next.bucket[HT_ADDR_BITS-1:0] = hash.hash_one[HT_ADDR_BITS-1:0];

        rec_next.hash = hash;
        rec_next.meta = meta;
        rec_next.key  = wide_key;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            ht_rd_cmd_valid <= 1'b0;
            lookup_valid    <= 1'b0;
        end else begin
            if (fire) begin
                ht_rd_cmd_valid <= 1'b1;
            end else if (!ht_rd_cmd_stall) begin
                ht_rd_cmd_valid <= 1'b0;
            end
            if (fire) begin
                lookup_valid <= 1'b1;
            end else if (lookup_ready) begin
                lookup_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fire) begin
            ht_rd_cmd <= cmd_next;
            lookup    <= rec_next;
        end
    end

endmodule

`default_nettype wire

/* source/request_splitter.sv */
/*
 * request_splitter
 * turns buffered request beats into one metadata record and a stream
 * of 64-bit key words, last word flagged from the header count
 */
`default_nettype none

module request_splitter
    import kv_pkg::*;
(
    input  wire logic                      clk,
    input  wire logic                      rst,
    input  wire req_beat_u                 beat,
    input  wire logic                      beat_valid,
    input  wire logic                      beat_last,
    output logic                           beat_ready,
    output logic      [META_WIDTH-1:0]     meta,
    output logic                           meta_valid,
    output logic      [KEY_WORD_WIDTH-1:0] key_word,
    output logic                           key_valid,
    output logic                           key_last,
    input  wire logic                      meta_ready,
    input  wire logic                      key_ready
);

    // header phase when low
    logic                                   in_key;
    // key words still owed by the request
    logic [$clog2(MAX_KEY_WORDS+1)-1:0]     remaining;
    // which half of the current key beat
    logic                                   word_idx;
    logic                                   word_take;

    // ------------------------------
    // beat decode
    // ------------------------------
    assign meta       = beat.hdr.meta;
    assign meta_valid = beat_valid && !in_key;

    assign key_word  = word_idx ? beat.keys.word_one : beat.keys.word_zero;
    assign key_valid = beat_valid && in_key;
    assign key_last  = (remaining == 1);
    assign word_take = key_valid && key_ready;

    // a key beat leaves with its final word
    always_comb begin
        if (in_key) begin
            beat_ready = key_ready && (word_idx || key_last);
        end else begin
            beat_ready = meta_ready;
        end
    end

    // ------------------------------
    // phase and word counting
    // ------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            in_key    <= 1'b0;
            remaining <= '0;
            word_idx  <= 1'b0;
        end else if (!in_key) begin
            if (beat_valid && meta_ready) begin
                in_key    <= 1'b1;
                remaining <= beat.hdr.key_count[$bits(remaining)-1:0];
                word_idx  <= 1'b0;
            end
        end else if (word_take) begin
            remaining <= remaining - 1'b1;
            if (key_last || (beat_ready && beat_last)) begin
                // end of request, or a stream marked short
                in_key   <= 1'b0;
                word_idx <= 1'b0;
            end else begin
                word_idx <= !word_idx;
            end
        end
    end

endmodule

`default_nettype wire

/* source/sync_fifo.sv */
/*
 * sync_fifo
 * single clock first-word-fall-through FIFO, RAM based,
 * with a registered ready flag
 */
`default_nettype none

module sync_fifo #(
    parameter int DATA_WIDTH = 32,
    parameter int ADDR_BITS  = 5
) (
    input  wire logic                  clk,
    input  wire logic                  rst,
    input  wire logic [DATA_WIDTH-1:0] in_data,
    input  wire logic                  in_valid,
    output logic                       in_ready,
    output logic      [DATA_WIDTH-1:0] out_data,
    output logic                       out_valid,
    input  wire logic                  out_ready
);

    logic [DATA_WIDTH-1:0] mem [2**ADDR_BITS];
    logic [ADDR_BITS-1:0]  wr_ptr;
    logic [ADDR_BITS-1:0]  rd_ptr;
    logic [ADDR_BITS:0]    count;
    logic [ADDR_BITS:0]    count_next;
    logic                  push;
    logic                  pop;

    assign push      = in_valid && in_ready;
    assign pop       = out_valid && out_ready;
    assign out_valid = (count != '0);
    // head entry shows without a read cycle
    assign out_data  = mem[rd_ptr];

    always_comb begin
        count_next = count;
        if (push && !pop) begin
            count_next = count + 1'b1;
        end else if (pop && !push) begin
            count_next = count - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= in_data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            in_ready <= 1'b0;
        end else begin
            wr_ptr   <= wr_ptr + ADDR_BITS'(push);
            rd_ptr   <= rd_ptr + ADDR_BITS'(pop);
            count    <= count_next;
            // full exactly when the top count bit is set
            in_ready <= !count_next[ADDR_BITS];
        end
    end

endmodule

`default_nettype wire
